/* test/agc_stim.txt */
// AGC test segments, one per line, hex words
// sample_low sample_high expected_gain_step expected_stable, a low of ffff ends the list
708 834 3 0   // swing 300, below every lower limit, climbs to GAIN_29_25
12C DAC 0 0   // swing 3200 under the overload level, falls to GAIN_3
578 A28 2 1   // swing 1200, inside the GAIN_13_5 limits, goes stable
76C F0A 0 0   // peak over the overload level, steps down although in range
3E8 DAC 0 1   // swing 2500, in range at GAIN_3, stable again
ffff ffff 0 0

/* flist.f */
+incdir+logic
logic/agc_pkg.sv
logic/meas_if.sv
logic/agc_apb_regs.sv
logic/pp_window_detector.sv
logic/gain_step_fsm.sv
logic/relay_settle_ctrl.sv
logic/agc_top.sv
test/tb_agc.sv

/* Makefile */
# Verilator build and run of the AGC testbench

VERILATOR ?= verilator
TOP       ?= tb_agc
FLIST     ?= flist.f
WINDOW    ?= 16
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard logic/*.sv logic/*.svh test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GWINDOW=$(WINDOW) -Mdir $(BUILD_DIR) -f $(FLIST)

# the log decides the result, the simulator status is not used
run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* test/tb_agc.sv */
// self-checking testbench for agc_top that programs limits over APB and plays the stim segments
`default_nettype none
`include "agc_config.svh"

module tb_agc #(
    parameter int WINDOW = 16
);
    import agc_pkg::*;

    localparam int HALF_PERIOD    = 10;
    localparam int WIN_CYCLES     = WINDOW + 40; // one window plus settle and restart
    localparam int CHANGE_TIMEOUT = 6 * WIN_CYCLES;
    localparam int STABLE_TIMEOUT = 6 * WIN_CYCLES;
    localparam int HOLD_CYCLES    = 3 * WIN_CYCLES;
    localparam int APB_TIMEOUT    = 8;
    localparam int MAX_SEG        = 16;

    // reset limits indexed by gain step
    localparam logic [11:0] RST_LO [4] = '{12'd1791, 12'd1791, 12'd1791, 12'd1798};
    localparam logic [11:0] RST_HI [4] = '{12'd3685, 12'd3883, 12'd3723, 12'd3883};
    localparam logic [11:0] RST_OVR    = 12'd3941;
    // limits this test writes
    localparam logic [11:0] PROG_LO [4] = '{12'd2000, 12'd1500, 12'd1000, 12'd800};
    localparam logic [11:0] PROG_HI [4] = '{12'd3000, 12'd2600, 12'd2000, 12'd1800};
    localparam logic [11:0] PROG_OVR    = 12'd3800;

    logic                   adc_clk;
    logic                   rst_n;
    logic [`AGC_APB_AW-1:0] paddr;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`AGC_APB_DW-1:0] pwdata;
    logic [`AGC_APB_DW-1:0] prdata;
    logic                   pready;
    logic [`AGC_DATA_W-1:0] adc_data;
    logic [1:0]             gain_ctrl;
    logic                   stable;

    logic [15:0]            stim_mem [0:4*MAX_SEG-1]; // lo, hi, gain, stable per segment
    logic [`AGC_DATA_W-1:0] seg_lo;
    logic [`AGC_DATA_W-1:0] seg_hi;
    logic [1:0]             model_gain;
    integer                 seed = 85228;
    int                     errors = 0;

    agc_top #(.WINDOW(WINDOW)) dut0 (
        .adc_clk  (adc_clk),
        .rst_n    (rst_n),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .adc_data (adc_data),
        .gain_ctrl(gain_ctrl),
        .stable   (stable)
    );

    initial begin
        adc_clk = 1'b0;
        forever #(HALF_PERIOD) adc_clk = ~adc_clk;
    end

    // samples come in low and high pairs with the coin picking the order
    initial begin
        logic [31:0] coin;
        logic        low_first;
        logic        second;
        adc_data  = '0;
        low_first = 1'b1;
        second    = 1'b0;
        forever begin
            @(negedge adc_clk);
            if (!second) begin
                coin      = $random(seed);
                low_first = coin[0];
                adc_data  = low_first ? seg_lo : seg_hi;
            end else begin
                adc_data = low_first ? seg_hi : seg_lo;
            end
            second = !second;
        end
    end

    task automatic stop_on_error(input string what);
        errors++;
        $display("%s", what);
        $display("TEST FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            stop_on_error($sformatf("CHECK FAILED at %0t: %s got 0x%0h expected 0x%0h",
                                    $time, name, got, exp));
    endtask

    function automatic logic [3:0] limit_index(input int s, input logic upper);
        return 4'(2 * s + int'(upper)); // lower then upper per step
    endfunction

    // gain FSM step rules where overload always steps down
    function automatic logic [1:0] next_gain(input logic [1:0] g, input logic [11:0] pp,
                                             input logic ovr);
        if (ovr || (pp > PROG_HI[g]))
            return (g == 2'd0) ? 2'd0 : g - 2'd1;
        else if (pp < PROG_LO[g])
            return (g == 2'd3) ? 2'd3 : g + 2'd1;
        return g;
    endfunction

    task automatic apb_access(input logic write, input logic [3:0] index,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int cycles;
        @(negedge adc_clk);
        paddr   = {index, 2'b00};
        pwrite  = write;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge adc_clk);
        penable = 1'b1; // access phase
        cycles  = 0;
        while (!pready && (cycles < APB_TIMEOUT)) begin
            @(negedge adc_clk);
            cycles++;
        end
        if (!pready)
            stop_on_error("APB slave never raised pready");
        rdata = prdata; // settled since the last rising edge
        @(negedge adc_clk); // transfer completes on the rising edge before this
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [3:0] index, input logic [31:0] data);
        logic [31:0] discard;
        apb_access(1'b1, index, data, discard);
    endtask

    task automatic apb_read_check(input logic [3:0] index, input logic [31:0] exp,
                                  input string name);
        logic [31:0] rd;
        apb_access(1'b0, index, 32'h0, rd);
        check_val(name, rd, exp);
    endtask

    // state bits [5:4] follow the FSM
    task automatic status_read_check(input logic [1:0] exp_gain, input logic exp_stable);
        logic [31:0] rd;
        apb_access(1'b0, REG_STATUS, 32'h0, rd);
        check_val("status", rd & 32'h0000_000f, {28'h0, 1'b0, exp_stable, exp_gain});
    endtask

    task automatic set_segment(input logic [11:0] lo, input logic [11:0] hi);
        @(posedge adc_clk); // sample driver picks them up on the next falling edge
        seg_lo = lo;
        seg_hi = hi;
    endtask

    task automatic wait_gain_change(input logic [1:0] from_gain);
        int cycles;
        cycles = 0;
        @(negedge adc_clk);
        while ((gain_ctrl == from_gain) && (cycles < CHANGE_TIMEOUT)) begin
            @(negedge adc_clk);
            cycles++;
        end
        if (gain_ctrl == from_gain)
            stop_on_error($sformatf("timeout, gain_ctrl stayed at %0d for %0d cycles",
                                    from_gain, cycles));
    endtask

    task automatic wait_stable(input logic [1:0] g);
        int cycles;
        cycles = 0;
        @(negedge adc_clk);
        while (!stable && (cycles < STABLE_TIMEOUT)) begin
            @(negedge adc_clk);
            check_val("gain_ctrl", 32'(gain_ctrl), 32'(g));
            cycles++;
        end
        if (!stable)
            stop_on_error($sformatf("timeout, stable did not rise within %0d cycles", cycles));
    endtask

    task automatic hold_gain(input logic [1:0] g);
        repeat (HOLD_CYCLES) begin
            @(negedge adc_clk);
            check_val("gain_ctrl", 32'(gain_ctrl), 32'(g));
        end
    endtask

    task automatic run_segment(input int idx);
        logic [11:0] lo;
        logic [11:0] hi;
        logic [11:0] pp;
        logic [1:0]  next;
        logic [1:0]  exp_gain;
        logic        exp_stable;
        logic        ovr;
        logic        done;
        lo         = stim_mem[4*idx][11:0];
        hi         = stim_mem[4*idx+1][11:0];
        exp_gain   = stim_mem[4*idx+2][1:0];
        exp_stable = stim_mem[4*idx+3][0];
        set_segment(lo, hi);
        pp   = hi - lo;
        ovr  = (hi >= PROG_OVR);
        done = 1'b0;
        while (!done) begin
            next = next_gain(model_gain, pp, ovr);
            if (next != model_gain) begin
                wait_gain_change(model_gain);
                check_val("gain_ctrl", 32'(gain_ctrl), 32'(next));
                check_val("stable", 32'(stable), 32'd0); // a step clears the run
                model_gain = next;
            end else if (ovr || (pp > PROG_HI[model_gain]) || (pp < PROG_LO[model_gain])) begin
                hold_gain(model_gain); // end stop with requests still coming
                check_val("stable", 32'(stable), 32'd0);
                done = 1'b1;
            end else begin
                wait_stable(model_gain);
                done = 1'b1;
            end
        end
        check_val("gain_ctrl", 32'(gain_ctrl), 32'(exp_gain));
        check_val("stable", 32'(stable), 32'(exp_stable));
        status_read_check(exp_gain, exp_stable);
    endtask

    initial begin
        int nseg;
        rst_n      = 1'b0;
        paddr      = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        pwdata     = '0;
        seg_lo     = '0;
        seg_hi     = '0;
        model_gain = GAIN_3;
        $readmemh("test/agc_stim.txt", stim_mem);
        repeat (5) @(negedge adc_clk);
        rst_n = 1'b1;
        @(negedge adc_clk);

        check_val("gain_ctrl", 32'(gain_ctrl), 32'(GAIN_3));
        check_val("stable", 32'(stable), 32'd0);
        for (int s = 0; s < 4; s++) begin
            apb_read_check(limit_index(s, 1'b0), 32'(RST_LO[s]), $sformatf("lim%0d_lo", s));
            apb_read_check(limit_index(s, 1'b1), 32'(RST_HI[s]), $sformatf("lim%0d_hi", s));
        end
        apb_read_check(REG_OVR_THRESH, 32'(RST_OVR), "ovr_thresh");
        apb_read_check(REG_CTRL, 32'h0, "ctrl");

        for (int s = 0; s < 4; s++) begin
            apb_write(limit_index(s, 1'b0), 32'(PROG_LO[s]));
            apb_write(limit_index(s, 1'b1), 32'(PROG_HI[s]));
        end
        apb_write(REG_OVR_THRESH, 32'(PROG_OVR));
        for (int s = 0; s < 4; s++) begin
            apb_read_check(limit_index(s, 1'b0), 32'(PROG_LO[s]), $sformatf("lim%0d_lo", s));
            apb_read_check(limit_index(s, 1'b1), 32'(PROG_HI[s]), $sformatf("lim%0d_hi", s));
        end
        apb_read_check(REG_OVR_THRESH, 32'(PROG_OVR), "ovr_thresh");
        apb_write(4'hB, 32'h5A5); // hole in the map
        apb_read_check(4'hB, 32'h0, "unmapped");
        apb_read_check(REG_STATUS, 32'h0, "status"); // gain and stable while disabled

        nseg = 0;
        while ((nseg < MAX_SEG) && (stim_mem[4*nseg] != 16'hffff))
            nseg++;
        if ((nseg == 0) || (nseg == MAX_SEG))
            stop_on_error("stim file has no segments or no end marker");
        set_segment(stim_mem[0][11:0], stim_mem[1][11:0]);
        apb_write(REG_CTRL, 32'h1);
        apb_read_check(REG_CTRL, 32'h1, "ctrl");

        for (int i = 0; i < nseg; i++)
            run_segment(i);

        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* logic/agc_top.sv */
// AGC top level joining the APB registers, window detector, gain FSM and relay driver
`default_nettype none
`include "agc_config.svh"

module agc_top #(
    parameter int WINDOW = `AGC_WINDOW
) (
    input  wire logic                   adc_clk,
    input  wire logic                   rst_n,
    input  wire logic [`AGC_APB_AW-1:0] paddr,
    input  wire logic                   psel,
    input  wire logic                   penable,
    input  wire logic                   pwrite,
    input  wire logic [`AGC_APB_DW-1:0] pwdata,
    output logic [`AGC_APB_DW-1:0]      prdata,
    output logic                        pready,
    input  wire logic [`AGC_DATA_W-1:0] adc_data,
    output logic [1:0]                  gain_ctrl,
    output logic                        stable
);
    import agc_pkg::*;

    gain_limit_t [3:0]      limits;
    logic [`AGC_DATA_W-1:0] ovr_thresh;
    logic                   enable;
    logic                   step_req;
    logic                   in_range;
    logic                   settled;
    gain_step_e             new_gain;
    gain_step_e             cur_gain;
    agc_state_e             state;

    meas_if meas ();

    agc_apb_regs u_regs (
        .adc_clk   (adc_clk),
        .rst_n     (rst_n),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .limits    (limits),
        .ovr_thresh(ovr_thresh),
        .enable    (enable),
        .cur_gain  (cur_gain),
        .stable    (stable),
        .state     (state)
    );

    pp_window_detector #(.WINDOW(WINDOW)) u_detect (
        .adc_clk   (adc_clk),
        .rst_n     (rst_n),
        .adc_data  (adc_data),
        .ovr_thresh(ovr_thresh),
        .meas      (meas.detector)
    );

    gain_step_fsm u_fsm (
        .adc_clk (adc_clk),
        .rst_n   (rst_n),
        .meas    (meas.evaluator),
        .limits  (limits),
        .enable  (enable),
        .cur_gain(cur_gain),
        .settled (settled),
        .step_req(step_req),
        .new_gain(new_gain),
        .in_range(in_range),
        .state   (state)
    );

    relay_settle_ctrl u_relay (
        .adc_clk  (adc_clk),
        .rst_n    (rst_n),
        .step_req (step_req),
        .new_gain (new_gain),
        .in_range (in_range),
        .gain_ctrl(gain_ctrl),
        .cur_gain (cur_gain),
        .settled  (settled),
        .stable   (stable)
    );

endmodule

`default_nettype wire

/* logic/relay_settle_ctrl.sv */
// relay driver holding the gain code, timing the settle interval and counting in-range windows
`default_nettype none
`include "agc_config.svh"

module relay_settle_ctrl (
    input  wire logic                adc_clk,
    input  wire logic                rst_n,
    input  wire logic                step_req,
    input  wire agc_pkg::gain_step_e new_gain,
    input  wire logic                in_range,
    output logic [1:0]               gain_ctrl,
    output agc_pkg::gain_step_e      cur_gain,
    output logic                     settled,
    output logic                     stable
);
    import agc_pkg::*;

    localparam int SETTLE_W = $clog2(`AGC_SETTLE + 1);
    localparam int STABLE_W = $clog2(`AGC_STABLE_WINDOWS + 1);

    gain_step_e          gain_q;
    logic [SETTLE_W-1:0] settle_cnt;
    logic [STABLE_W-1:0] stable_cnt;
    logic                settled_q;

    always_ff @(posedge adc_clk or negedge rst_n) begin
        if (!rst_n) begin
            gain_q     <= GAIN_3;
            settle_cnt <= '0;
            stable_cnt <= '0;
            settled_q  <= 1'b0;
        end else begin
            settled_q <= (settle_cnt == SETTLE_W'(1)); // last settle cycle
            if (step_req) begin
                gain_q     <= new_gain;
                settle_cnt <= SETTLE_W'(`AGC_SETTLE);
                stable_cnt <= '0; // any step breaks the run
            end else begin
                if (settle_cnt != '0)
                    settle_cnt <= settle_cnt - 1'b1;
                if (in_range && !stable)
                    stable_cnt <= stable_cnt + 1'b1;
            end
        end
    end

    assign gain_ctrl = gain_q;
    assign cur_gain  = gain_q;
    assign settled   = settled_q;
    assign stable    = (stable_cnt == STABLE_W'(`AGC_STABLE_WINDOWS));

    a_settle_no_overlap: assert property (@(posedge adc_clk) disable iff (!rst_n)
        !(settled && step_req));

endmodule

`default_nettype wire

/* logic/gain_step_fsm.sv */
// gain-step FSM that checks windows against the current step's limits and requests relay steps
`default_nettype none
`include "agc_config.svh"

module gain_step_fsm (
    input  wire logic                       adc_clk,
    input  wire logic                       rst_n,
    meas_if.evaluator                       meas,
    input  wire agc_pkg::gain_limit_t [3:0] limits,
    input  wire logic                       enable,
    input  wire agc_pkg::gain_step_e        cur_gain,
    input  wire logic                       settled,
    output logic                            step_req,
    output agc_pkg::gain_step_e             new_gain,
    output logic                            in_range,
    output agc_pkg::agc_state_e             state
);
    import agc_pkg::*;

    agc_state_e state_q;
    agc_state_e state_d;
    gain_step_e target_q;
    gain_step_e target_d;
    logic       too_big;
    logic       too_small;

    // both ends saturate while the request still goes out
    function automatic gain_step_e step_dn(gain_step_e g);
        return (g == GAIN_3) ? GAIN_3 : gain_step_e'(g - 2'd1);
    endfunction

    function automatic gain_step_e step_up(gain_step_e g);
        return (g == GAIN_29_25) ? GAIN_29_25 : gain_step_e'(g + 2'd1);
    endfunction

    assign too_big   = meas.pp_value > limits[cur_gain].upper;
    assign too_small = meas.pp_value < limits[cur_gain].lower;

    always_comb begin
        state_d  = state_q;
        target_d = target_q;
        case (state_q)
            SAMPLE: begin
                if (enable && meas.overload) begin // wins over a coincident window end
                    target_d = step_dn(cur_gain);
                    state_d  = ADJUST;
                end else if (enable && meas.window_done) begin
                    state_d = EVALUATE;
                end
            end
            EVALUATE: begin
                if (too_big) begin
                    target_d = step_dn(cur_gain);
                    state_d  = ADJUST;
                end else if (too_small) begin
                    target_d = step_up(cur_gain);
                    state_d  = ADJUST;
                end else begin
                    state_d = SAMPLE; // in range so start the next window
                end
            end
            ADJUST: state_d = SETTLE;
            SETTLE: begin
                if (settled)
                    state_d = SAMPLE;
            end
            default: state_d = SAMPLE;
        endcase
    end

    always_ff @(posedge adc_clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= SAMPLE;
            target_q <= GAIN_3;
        end else begin
            state_q  <= state_d;
            target_q <= target_d;
        end
    end

    assign step_req     = (state_q == ADJUST);
    assign new_gain     = target_q;
    assign in_range     = (state_q == EVALUATE) && !too_big && !too_small;
    assign state        = state_q;
    assign meas.restart = (state_q != SAMPLE) || !enable; // detector idle outside SAMPLE

    // the relay moves by one step at most per request
    a_single_step: assert property (@(posedge adc_clk) disable iff (!rst_n)
        step_req |-> ((int'(new_gain) - int'(cur_gain)) inside {-1, 0, 1}));

    // relay driver only reports settling while this FSM waits for it
    a_settled_in_settle: assert property (@(posedge adc_clk) disable iff (!rst_n)
        settled |-> state_q == SETTLE);

endmodule

`default_nettype wire

/* logic/pp_window_detector.sv */
// windowed peak-to-peak detector with per-sample overload flag, feeds the gain FSM over meas_if
`default_nettype none
`include "agc_config.svh"

module pp_window_detector #(
    parameter int WINDOW = `AGC_WINDOW
) (
    input  wire logic                   adc_clk,
    input  wire logic                   rst_n,
    input  wire logic [`AGC_DATA_W-1:0] adc_data,
    input  wire logic [`AGC_DATA_W-1:0] ovr_thresh,
    meas_if.detector                    meas
);
    localparam int CNT_W = (WINDOW > 1) ? $clog2(WINDOW) : 1;

    logic [`AGC_DATA_W-1:0] sample_q;
    logic [`AGC_DATA_W-1:0] peak_q;
    logic [`AGC_DATA_W-1:0] valley_q;
    logic [`AGC_DATA_W-1:0] peak_d;
    logic [`AGC_DATA_W-1:0] valley_d;
    logic [`AGC_DATA_W-1:0] pp_q;
    logic [CNT_W-1:0]       cnt_q;
    logic                   restart_d1;
    logic                   full_q;
    logic                   done_q;
    logic                   ovr_q;
    logic                   take;
    logic                   last;

    // sample_q still holds a restart-era sample in the first cycle after release
    assign take = !meas.restart && !restart_d1 && !full_q;
    assign last = take && (cnt_q == CNT_W'(WINDOW - 1));

    always_comb begin
        peak_d   = peak_q;
        valley_d = valley_q;
        if (take && (sample_q > peak_q))
            peak_d = sample_q;
        if (take && (sample_q < valley_q))
            valley_d = sample_q;
    end

    always_ff @(posedge adc_clk) begin
        sample_q <= adc_data; // input register
        if (last)
            pp_q <= peak_d - valley_d; // includes the final sample
    end

    always_ff @(posedge adc_clk or negedge rst_n) begin
        if (!rst_n) begin
            restart_d1 <= 1'b1;
            peak_q     <= '0;
            valley_q   <= '1;
            cnt_q      <= '0;
            full_q     <= 1'b0;
            done_q     <= 1'b0;
            ovr_q      <= 1'b0;
        end else begin
            restart_d1 <= meas.restart;
            if (meas.restart) begin
                peak_q   <= '0;
                valley_q <= '1;
                cnt_q    <= '0;
                full_q   <= 1'b0;
                done_q   <= 1'b0;
                ovr_q    <= 1'b0;
            end else begin
                peak_q   <= peak_d;
                valley_q <= valley_d;
                done_q   <= last;
                ovr_q    <= take && (sample_q >= ovr_thresh);
                if (last)
                    full_q <= 1'b1; // hold result until restart
                else if (take)
                    cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    assign meas.window_done = done_q;
    assign meas.pp_value    = pp_q;
    assign meas.overload    = ovr_q;

endmodule

`default_nettype wire

/* logic/agc_apb_regs.sv */
// APB slave holding the per-step limits, overload threshold and enable, and reporting status
`default_nettype none
`include "agc_config.svh"

module agc_apb_regs (
    input  wire logic                     adc_clk,
    input  wire logic                     rst_n,
    input  wire logic [`AGC_APB_AW-1:0]   paddr,
    input  wire logic                     psel,
    input  wire logic                     penable,
    input  wire logic                     pwrite,
    input  wire logic [`AGC_APB_DW-1:0]   pwdata,
    output logic [`AGC_APB_DW-1:0]        prdata,
    output logic                          pready,
    output agc_pkg::gain_limit_t [3:0]    limits,
    output logic [`AGC_DATA_W-1:0]        ovr_thresh,
    output logic                          enable,
    input  wire agc_pkg::gain_step_e      cur_gain,
    input  wire logic                     stable,
    input  wire agc_pkg::agc_state_e      state
);
    import agc_pkg::*;

    gain_limit_t [3:0]      lim_q;
    logic [`AGC_DATA_W-1:0] thresh_q;
    logic                   enable_q;
    agc_reg_e               reg_addr;
    logic [1:0]             lim_idx;
    logic                   wr_en;

    assign reg_addr = agc_reg_e'(paddr[`AGC_APB_AW-1:2]);
    assign lim_idx  = paddr[4:3]; // gain step of a limit word
    assign wr_en    = psel && penable && pwrite;

    always_ff @(posedge adc_clk or negedge rst_n) begin
        if (!rst_n) begin
            lim_q[0] <= '{lower: `AGC_LIM0_LO, upper: `AGC_LIM0_HI};
            lim_q[1] <= '{lower: `AGC_LIM1_LO, upper: `AGC_LIM1_HI};
            lim_q[2] <= '{lower: `AGC_LIM2_LO, upper: `AGC_LIM2_HI};
            lim_q[3] <= '{lower: `AGC_LIM3_LO, upper: `AGC_LIM3_HI};
            thresh_q <= `AGC_OVR_RESET;
            enable_q <= 1'b0;
        end else if (wr_en) begin
            case (reg_addr)
                REG_LIM0_LO, REG_LIM1_LO, REG_LIM2_LO, REG_LIM3_LO:
                    lim_q[lim_idx].lower <= pwdata[`AGC_DATA_W-1:0];
                REG_LIM0_HI, REG_LIM1_HI, REG_LIM2_HI, REG_LIM3_HI:
                    lim_q[lim_idx].upper <= pwdata[`AGC_DATA_W-1:0];
                REG_OVR_THRESH: thresh_q <= pwdata[`AGC_DATA_W-1:0];
                REG_CTRL:       enable_q <= pwdata[0];
                default: ; // status and holes ignore writes
            endcase
        end
    end

    // read data valid whenever the slave is selected
    always_comb begin
        prdata = '0;
        if (psel) begin
            case (reg_addr)
                REG_LIM0_LO, REG_LIM1_LO, REG_LIM2_LO, REG_LIM3_LO:
                    prdata[`AGC_DATA_W-1:0] = lim_q[lim_idx].lower;
                REG_LIM0_HI, REG_LIM1_HI, REG_LIM2_HI, REG_LIM3_HI:
                    prdata[`AGC_DATA_W-1:0] = lim_q[lim_idx].upper;
                REG_OVR_THRESH: prdata[`AGC_DATA_W-1:0] = thresh_q;
                REG_CTRL:       prdata[0] = enable_q;
                REG_STATUS:     prdata[5:0] = {state, 1'b0, stable, cur_gain}; // [5:4] [2] [1:0]
                default:        prdata = '0;
            endcase
        end
    end

    assign pready     = 1'b1; // no wait states
    assign limits     = lim_q;
    assign ovr_thresh = thresh_q;
    assign enable     = enable_q;

    // every access phase must follow a setup phase of the same transfer
    a_apb_setup_first: assert property (@(posedge adc_clk) disable iff (!rst_n)
        penable |-> psel && $past(psel));

endmodule

`default_nettype wire

/* logic/meas_if.sv */
// window measurement bundle between the peak detector and the gain-step FSM
`default_nettype none
`include "agc_config.svh"

interface meas_if;

    logic                   window_done; // one cycle at window end
    logic [`AGC_DATA_W-1:0] pp_value;    // held until restart
    logic                   overload;    // one cycle per hot sample
    logic                   restart;     // clears peak, valley and count

    modport detector (output window_done, pp_value, overload, input restart);

    modport evaluator (input window_done, pp_value, overload, output restart);

endinterface

`default_nettype wire

/* logic/agc_pkg.sv */
// shared AGC types (gain steps, FSM states, APB register map, limit pair), imported by the RTL
`default_nettype none
`include "agc_config.svh"

package agc_pkg;

    // value doubles as the relay code
    typedef enum logic [1:0] {
        GAIN_3     = 2'd0,
        GAIN_6_5   = 2'd1,
        GAIN_13_5  = 2'd2,
        GAIN_29_25 = 2'd3
    } gain_step_e;

    typedef enum logic [1:0] {
        SAMPLE,
        EVALUATE,
        ADJUST,
        SETTLE
    } agc_state_e;

    // word index, byte address is index times four
    typedef enum logic [3:0] {
        REG_LIM0_LO    = 4'h0,
        REG_LIM0_HI    = 4'h1,
        REG_LIM1_LO    = 4'h2,
        REG_LIM1_HI    = 4'h3,
        REG_LIM2_LO    = 4'h4,
        REG_LIM2_HI    = 4'h5,
        REG_LIM3_LO    = 4'h6,
        REG_LIM3_HI    = 4'h7,
        REG_OVR_THRESH = 4'h8,
        REG_CTRL       = 4'h9, // bit 0 enable
        REG_STATUS     = 4'hA  // read only
    } agc_reg_e;

    typedef struct packed {
        logic [`AGC_DATA_W-1:0] lower; // peak-to-peak, inclusive
        logic [`AGC_DATA_W-1:0] upper;
    } gain_limit_t;

endpackage

`default_nettype wire

/* logic/agc_config.svh */
// AGC build constants (sample width, APB sizes, window, settle time, reset limits) for all RTL
`ifndef AGC_CONFIG_SVH
`define AGC_CONFIG_SVH

`define AGC_DATA_W         12
`define AGC_APB_AW         6      // byte address, word index in [5:2]
`define AGC_APB_DW         32
`define AGC_WINDOW         512    // samples per window, agc_top passes it down as WINDOW
`define AGC_SETTLE         10     // relay settle cycles after a gain change
`define AGC_STABLE_WINDOWS 3

// overload level, about 1925 mV at the ADC
`define AGC_OVR_RESET      12'd3941

// peak-to-peak limits per gain step after reset
`define AGC_LIM0_LO        12'd1791
`define AGC_LIM0_HI        12'd3685
`define AGC_LIM1_LO        12'd1791
`define AGC_LIM1_HI        12'd3883
`define AGC_LIM2_LO        12'd1791
`define AGC_LIM2_HI        12'd3723
`define AGC_LIM3_LO        12'd1798
`define AGC_LIM3_HI        12'd3883
`endif
